// File: verilog/soc_pkg.sv
package soc_pkg;

  localparam int unsigned NR_LANES     = 4;
  localparam int unsigned LANE_W       = 32;
  localparam int unsigned DATA_W       = NR_LANES * LANE_W;
  localparam int unsigned BE_W         = DATA_W / 8;
  localparam int unsigned LANE_BE_W    = LANE_W / 8;
  localparam int unsigned ADDR_W       = 32;
  localparam int unsigned L2_WORDS     = 256;
  localparam int unsigned L2_IDX_W     = $clog2(L2_WORDS);
  // Byte offset inside one wide word
  localparam int unsigned L2_IDX_LSB   = $clog2(BE_W);
  localparam int unsigned LANE_SEL_W   = $clog2(NR_LANES);
  localparam int unsigned LANE_SEL_LSB = $clog2(LANE_BE_W);
  localparam int unsigned REG_OFS_W    = 12;

  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [ADDR_W-1:0] addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  localparam addr_t DRAM_BASE = 32'h8000_0000;
  localparam addr_t DRAM_LEN  = 32'h0000_1000;
  localparam addr_t UART_BASE = 32'hC000_0000;
  localparam addr_t UART_LEN  = 32'h0000_1000;
  localparam addr_t CTRL_BASE = 32'hD000_0000;
  localparam addr_t CTRL_LEN  = 32'h0000_1000;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_BUSY,
    DEC_ACK
  } dec_state_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  typedef enum logic [REG_OFS_W-1:0] {
    REG_EXIT_LO   = 12'h000,
    REG_EXIT_HI   = 12'h004,
    REG_CNT_EN_LO = 12'h008,
    REG_CNT_EN_HI = 12'h00C,
    REG_DRAM_BASE = 12'h010,
    REG_DRAM_LEN  = 12'h014
  } ctrl_reg_e;

  // Narrow lane chosen by address bits 3:2
  function automatic logic [LANE_SEL_W-1:0] lane_idx(addr_t addr);
    return addr[LANE_SEL_LSB +: LANE_SEL_W];
  endfunction

  function automatic lane_t lane_get(data_t data, addr_t addr);
    return data[lane_idx(addr)*LANE_W +: LANE_W];
  endfunction

  function automatic logic [LANE_BE_W-1:0] lane_be(be_t be, addr_t addr);
    return be[lane_idx(addr)*LANE_BE_W +: LANE_BE_W];
  endfunction

  // Other lanes read as zero
  function automatic data_t lane_put(lane_t word, addr_t addr);
    data_t data;
    data = '0;
    data[lane_idx(addr)*LANE_W +: LANE_W] = word;
    return data;
  endfunction

  function automatic lane_t byte_merge(lane_t old_word, lane_t new_word,
                                       logic [LANE_BE_W-1:0] be);
    lane_t word;
    word = old_word;
    for (int b = 0; b < LANE_BE_W; b++) begin
      if (be[b]) begin
        word[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return word;
  endfunction

endpackage

// File: verilog/soc_bus_if.sv
interface soc_bus_if;

  // Request side, held by the decoder until done
  logic           sel;
  logic           we;
  soc_pkg::addr_t addr;
  soc_pkg::data_t wdata;
  soc_pkg::be_t   be;

  // Response side
  soc_pkg::data_t rdata;
  logic           err;
  logic           done;

  modport initiator (
    output sel, we, addr, wdata, be,
    input  rdata, err, done
  );

  modport target (
    input  sel, we, addr, wdata, be,
    output rdata, err, done
  );

endinterface

// File: verilog/l2_lane_bank.sv
module l2_lane_bank (
  input  logic                          clk_i,
  input  logic                          sel_i,
  input  logic                          we_i,
  input  logic [soc_pkg::L2_IDX_W-1:0]  idx_i,
  input  soc_pkg::lane_t                wdata_i,
  input  logic [soc_pkg::LANE_BE_W-1:0] be_i,
  output soc_pkg::lane_t                rdata_o
);

  soc_pkg::lane_t mem_q [soc_pkg::L2_WORDS];

  // One-cycle read latency
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        mem_q[idx_i] <= soc_pkg::byte_merge(mem_q[idx_i], wdata_i, be_i);
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

// File: verilog/l2_read_merge.sv
module l2_read_merge (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  soc_pkg::lane_t [soc_pkg::NR_LANES-1:0] lane_rdata_i,
  soc_bus_if.target                              bus
);

  logic           done_q;
  soc_pkg::data_t merged;

  // Banks answer one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= bus.sel;
    end
  end

  always_comb begin
    merged = '0;
    for (int i = 0; i < soc_pkg::NR_LANES; i++) begin
      merged[i*soc_pkg::LANE_W +: soc_pkg::LANE_W] = lane_rdata_i[i];
    end
  end

  assign bus.done  = done_q;
  assign bus.rdata = bus.we ? '0 : merged;
  assign bus.err   = 1'b0;

endmodule

// File: verilog/uart_apb_bridge.sv
module uart_apb_bridge (
  input  logic        clk_i,
  input  logic        reset_i,
  soc_bus_if.target   bus,
  output logic        psel_o,
  output logic        penable_o,
  output logic        pwrite_o,
  output logic [31:0] paddr_o,
  output logic [31:0] pwdata_o,
  input  logic [31:0] prdata_i,
  input  logic        pready_i,
  input  logic        pslverr_i
);

  soc_pkg::apb_state_e state_q;
  logic                done_q;
  logic                err_q;
  soc_pkg::data_t      rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= soc_pkg::APB_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        soc_pkg::APB_IDLE: begin
          if (bus.sel) begin
            state_q <= soc_pkg::APB_SETUP;
          end
        end
        soc_pkg::APB_SETUP: state_q <= soc_pkg::APB_ACCESS;
        soc_pkg::APB_ACCESS: begin
          // Stretched until the slave is ready
          if (pready_i) begin
            state_q <= soc_pkg::APB_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= soc_pkg::APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::APB_ACCESS && pready_i) begin
      rdata_q <= bus.we ? '0 : soc_pkg::lane_put(prdata_i, bus.addr);
      err_q   <= pslverr_i;
    end
  end

  assign psel_o    = (state_q != soc_pkg::APB_IDLE);
  assign penable_o = (state_q == soc_pkg::APB_ACCESS);
  assign pwrite_o  = bus.we;
  assign paddr_o   = bus.addr;
  assign pwdata_o  = soc_pkg::lane_get(bus.wdata, bus.addr);

  assign bus.done  = done_q;
  assign bus.rdata = rdata_q;
  assign bus.err   = err_q;

endmodule

// File: verilog/ctrl_registers.sv
module ctrl_registers (
  input  logic        clk_i,
  input  logic        reset_i,
  soc_bus_if.target   bus,
  output logic [63:0] exit_o,
  output logic [63:0] hw_cnt_en_o
);

  logic [63:0]                   exit_q;
  logic [63:0]                   cnt_en_q;
  logic [soc_pkg::REG_OFS_W-1:0] ofs;
  soc_pkg::lane_t                wr_word;
  logic [soc_pkg::LANE_BE_W-1:0] wr_be;
  soc_pkg::lane_t                rd_word;

  assign ofs     = bus.addr[soc_pkg::REG_OFS_W-1:0];
  assign wr_word = soc_pkg::lane_get(bus.wdata, bus.addr);
  assign wr_be   = soc_pkg::lane_be(bus.be, bus.addr);

  // Read-only and unknown offsets drop the write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else if (bus.sel && bus.we) begin
      case (ofs)
        soc_pkg::REG_EXIT_LO:
          exit_q[31:0] <= soc_pkg::byte_merge(exit_q[31:0], wr_word, wr_be);
        soc_pkg::REG_EXIT_HI:
          exit_q[63:32] <= soc_pkg::byte_merge(exit_q[63:32], wr_word, wr_be);
        soc_pkg::REG_CNT_EN_LO:
          cnt_en_q[31:0] <= soc_pkg::byte_merge(cnt_en_q[31:0], wr_word, wr_be);
        soc_pkg::REG_CNT_EN_HI:
          cnt_en_q[63:32] <= soc_pkg::byte_merge(cnt_en_q[63:32], wr_word, wr_be);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (ofs)
      soc_pkg::REG_EXIT_LO:   rd_word = exit_q[31:0];
      soc_pkg::REG_EXIT_HI:   rd_word = exit_q[63:32];
      soc_pkg::REG_CNT_EN_LO: rd_word = cnt_en_q[31:0];
      soc_pkg::REG_CNT_EN_HI: rd_word = cnt_en_q[63:32];
      soc_pkg::REG_DRAM_BASE: rd_word = soc_pkg::DRAM_BASE;
      soc_pkg::REG_DRAM_LEN:  rd_word = soc_pkg::DRAM_LEN;
      default:                rd_word = '0;
    endcase
  end

  // Answer in the strobe cycle
  assign bus.done  = bus.sel;
  assign bus.rdata = bus.we ? '0 : soc_pkg::lane_put(rd_word, bus.addr);
  assign bus.err   = 1'b0;

  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

// File: verilog/soc_addr_decoder.sv
module soc_addr_decoder (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_i,
  input  logic                we_i,
  input  soc_pkg::addr_t      addr_i,
  input  soc_pkg::data_t      wdata_i,
  input  soc_pkg::be_t        be_i,
  output logic                ack_o,
  output logic                err_o,
  output soc_pkg::data_t      rdata_o,
  soc_bus_if.initiator        l2_bus,
  soc_bus_if.initiator        uart_bus,
  soc_bus_if.initiator        ctrl_bus
);

  soc_pkg::dec_state_e state_q;
  soc_pkg::target_e    tgt_q;
  soc_pkg::target_e    dec_tgt;
  logic                sel_q;
  logic                we_q;
  soc_pkg::addr_t      addr_q;
  soc_pkg::data_t      wdata_q;
  soc_pkg::be_t        be_q;
  logic                tgt_done;
  logic                tgt_err;
  soc_pkg::data_t      tgt_rdata;

  function automatic logic in_window(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                     soc_pkg::addr_t len);
    return (addr - base) < len;
  endfunction

  always_comb begin
    if (in_window(addr_i, soc_pkg::DRAM_BASE, soc_pkg::DRAM_LEN)) begin
      dec_tgt = soc_pkg::TGT_L2;
    end else if (in_window(addr_i, soc_pkg::UART_BASE, soc_pkg::UART_LEN)) begin
      dec_tgt = soc_pkg::TGT_UART;
    end else if (in_window(addr_i, soc_pkg::CTRL_BASE, soc_pkg::CTRL_LEN)) begin
      dec_tgt = soc_pkg::TGT_CTRL;
    end else begin
      dec_tgt = soc_pkg::TGT_NONE;
    end
  end

  // Response of the target in flight
  always_comb begin
    tgt_done  = 1'b0;
    tgt_err   = 1'b0;
    tgt_rdata = '0;
    unique case (tgt_q)
      soc_pkg::TGT_L2: begin
        tgt_done  = l2_bus.done;
        tgt_err   = l2_bus.err;
        tgt_rdata = l2_bus.rdata;
      end
      soc_pkg::TGT_UART: begin
        tgt_done  = uart_bus.done;
        tgt_err   = uart_bus.err;
        tgt_rdata = uart_bus.rdata;
      end
      soc_pkg::TGT_CTRL: begin
        tgt_done  = ctrl_bus.done;
        tgt_err   = ctrl_bus.err;
        tgt_rdata = ctrl_bus.rdata;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= soc_pkg::DEC_IDLE;
      tgt_q   <= soc_pkg::TGT_NONE;
      sel_q   <= 1'b0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      unique case (state_q)
        soc_pkg::DEC_IDLE: begin
          if (req_i) begin
            tgt_q <= dec_tgt;
            if (dec_tgt == soc_pkg::TGT_NONE) begin
              // Unmapped address answers at once
              state_q <= soc_pkg::DEC_ACK;
              ack_o   <= 1'b1;
              err_o   <= 1'b1;
            end else begin
              state_q <= soc_pkg::DEC_BUSY;
              sel_q   <= 1'b1;
            end
          end
        end
        soc_pkg::DEC_BUSY: begin
          sel_q <= 1'b0;
          if (tgt_done) begin
            state_q <= soc_pkg::DEC_ACK;
            ack_o   <= 1'b1;
            err_o   <= tgt_err;
          end
        end
        soc_pkg::DEC_ACK: begin
          if (!req_i) begin
            state_q <= soc_pkg::DEC_IDLE;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
          end
        end
        default: state_q <= soc_pkg::DEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::DEC_IDLE && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
      rdata_o <= '0;
    end else if (state_q == soc_pkg::DEC_BUSY && tgt_done) begin
      rdata_o <= tgt_rdata;
    end
  end

  // Only the chosen target sees the strobe
  assign l2_bus.sel   = sel_q && (tgt_q == soc_pkg::TGT_L2);
  assign uart_bus.sel = sel_q && (tgt_q == soc_pkg::TGT_UART);
  assign ctrl_bus.sel = sel_q && (tgt_q == soc_pkg::TGT_CTRL);

  assign l2_bus.we      = we_q;
  assign l2_bus.addr    = addr_q;
  assign l2_bus.wdata   = wdata_q;
  assign l2_bus.be      = be_q;
  assign uart_bus.we    = we_q;
  assign uart_bus.addr  = addr_q;
  assign uart_bus.wdata = wdata_q;
  assign uart_bus.be    = be_q;
  assign ctrl_bus.we    = we_q;
  assign ctrl_bus.addr  = addr_q;
  assign ctrl_bus.wdata = wdata_q;
  assign ctrl_bus.be    = be_q;

endmodule

// File: verilog/soc_top.sv
module soc_top (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::be_t   be_i,
  output logic           ack_o,
  output logic           err_o,
  output soc_pkg::data_t rdata_o,
  output logic [63:0]    exit_o,
  output logic [63:0]    hw_cnt_en_o,
  output logic           uart_psel_o,
  output logic           uart_penable_o,
  output logic           uart_pwrite_o,
  output logic [31:0]    uart_paddr_o,
  output logic [31:0]    uart_pwdata_o,
  input  logic [31:0]    uart_prdata_i,
  input  logic           uart_pready_i,
  input  logic           uart_pslverr_i
);

  soc_bus_if l2_bus ();
  soc_bus_if uart_bus ();
  soc_bus_if ctrl_bus ();

  soc_addr_decoder i_decoder (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .ack_o   (ack_o),
    .err_o   (err_o),
    .rdata_o (rdata_o),
    .l2_bus  (l2_bus),
    .uart_bus(uart_bus),
    .ctrl_bus(ctrl_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // L2 memory
  ////////////////////////////////////////////////////////////////////////////

  soc_pkg::lane_t [soc_pkg::NR_LANES-1:0] lane_rdata;

  for (genvar i = 0; i < soc_pkg::NR_LANES; i++) begin : g_lane
    l2_lane_bank i_bank (
      .clk_i  (clk_i),
      .sel_i  (l2_bus.sel),
      .we_i   (l2_bus.we),
      .idx_i  (l2_bus.addr[soc_pkg::L2_IDX_LSB +: soc_pkg::L2_IDX_W]),
      .wdata_i(l2_bus.wdata[i*soc_pkg::LANE_W +: soc_pkg::LANE_W]),
      .be_i   (l2_bus.be[i*soc_pkg::LANE_BE_W +: soc_pkg::LANE_BE_W]),
      .rdata_o(lane_rdata[i])
    );
  end

  l2_read_merge i_l2_merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .lane_rdata_i(lane_rdata),
    .bus         (l2_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////////////////////////////////////////

  uart_apb_bridge i_uart_bridge (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .bus      (uart_bus),
    .psel_o   (uart_psel_o),
    .penable_o(uart_penable_o),
    .pwrite_o (uart_pwrite_o),
    .paddr_o  (uart_paddr_o),
    .pwdata_o (uart_pwdata_o),
    .prdata_i (uart_prdata_i),
    .pready_i (uart_pready_i),
    .pslverr_i(uart_pslverr_i)
  );

  ctrl_registers i_ctrl_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .bus        (ctrl_bus),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 8 cycles and released just after an edge
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

// File: dv/tb_soc_asserts.sv
module tb_soc_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic req_i,
  input logic ack_i,
  input logic err_i,
  input logic psel_i,
  input logic penable_i
);

  // The acknowledge only answers a pending request
  ack_needs_req: assert property (
    @(posedge clk_i) disable iff (reset_i) $rose(ack_i) |-> $past(req_i)
  ) else $error("ack_o rose while req_i was low");

  err_with_ack: assert property (
    @(posedge clk_i) disable iff (reset_i) err_i |-> ack_i
  ) else $error("err_o high without ack_o");

  penable_with_psel: assert property (
    @(posedge clk_i) disable iff (reset_i) penable_i |-> psel_i
  ) else $error("uart_penable_o high without uart_psel_o");

  ack_low_after_reset: assert property (
    @(posedge clk_i) reset_i |=> !ack_i
  ) else $error("ack_o high in the cycle after reset");

endmodule

bind soc_top tb_soc_asserts i_asserts (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .err_i    (err_o),
  .psel_i   (uart_psel_o),
  .penable_i(uart_penable_o)
);

// File: dv/tb_soc.sv
module tb_soc;

  localparam int          MAX_TESTS   = 64;
  localparam int          FIELDS      = 6;
  localparam int unsigned WAIT_LIMIT  = 50;
  localparam int unsigned RESET_LIMIT = 40;
  localparam logic [1:0]  OP_READ     = 2'd0;
  localparam logic [1:0]  OP_WRITE    = 2'd1;
  localparam logic [1:0]  OP_EXIT     = 2'd2;
  localparam logic [1:0]  OP_CNT_EN   = 2'd3;

  logic         clk;
  logic         reset;
  logic         req;
  logic         we;
  logic [31:0]  addr;
  logic [127:0] wdata;
  logic [15:0]  be;
  logic         ack;
  logic         err;
  logic [127:0] rdata;
  logic [63:0]  exit_val;
  logic [63:0]  cnt_en;
  logic         uart_psel;
  logic         uart_penable;
  logic         uart_pwrite;
  logic [31:0]  uart_paddr;
  logic [31:0]  uart_pwdata;
  logic [31:0]  uart_prdata;
  logic         uart_pready;
  logic         uart_pslverr;

  // Six fields per access in file order
  logic [127:0] tests [MAX_TESTS*FIELDS];

  int           checks;
  int           errors;
  int           timeouts;
  int           apb_xfers;
  logic [31:0]  apb_addr;
  logic [31:0]  apb_wdata;
  logic         apb_write;
  logic         apb_setup;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .reset_o(reset)
  );

  soc_top dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .req_i         (req),
    .we_i          (we),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .be_i          (be),
    .ack_o         (ack),
    .err_o         (err),
    .rdata_o       (rdata),
    .exit_o        (exit_val),
    .hw_cnt_en_o   (cnt_en),
    .uart_psel_o   (uart_psel),
    .uart_penable_o(uart_penable),
    .uart_pwrite_o (uart_pwrite),
    .uart_paddr_o  (uart_paddr),
    .uart_pwdata_o (uart_pwdata),
    .uart_prdata_i (uart_prdata),
    .uart_pready_i (uart_pready),
    .uart_pslverr_i(uart_pslverr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : apb_slave
    int unsigned wait_cnt;
    logic        in_setup;
    wait_cnt     = 0;
    in_setup     = 1'b0;
    uart_pready  = 1'b0;
    uart_prdata  = '0;
    uart_pslverr = 1'b0;
    apb_xfers    = 0;
    apb_addr     = '0;
    apb_wdata    = '0;
    apb_write    = 1'b0;
    apb_setup    = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (uart_penable !== 1'b1) begin
        uart_pready  = 1'b0;
        uart_pslverr = 1'b0;
        wait_cnt     = 0;
      end else if (!uart_pready) begin
        // First access cycle follows a setup cycle
        if (wait_cnt == 0) begin
          apb_setup = in_setup;
        end
        apb_addr  = uart_paddr;
        apb_wdata = uart_pwdata;
        apb_write = uart_pwrite;
        // Ready two cycles into the access phase
        if (wait_cnt == 2) begin
          uart_pready  = 1'b1;
          uart_prdata  = uart_paddr ^ 32'h5A5A5A5A;
          uart_pslverr = (uart_paddr[11:0] >= 12'h800);
          apb_xfers++;
        end else begin
          wait_cnt++;
        end
      end
      in_setup = (uart_psel === 1'b1) && (uart_penable !== 1'b1);
    end
  end

  function automatic logic [31:0] pick_lane(input logic [127:0] data, input logic [31:0] a);
    return data[{a[3:2], 5'b0} +: 32];
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic do_access(input logic write, input logic [31:0] a, input logic [127:0] d,
                           input logic [15:0] b, output logic [127:0] got_rdata,
                           output logic got_err, output logic ok);
    int unsigned cnt;
    int unsigned hold;
    int unsigned gap;
    ok        = 1'b1;
    got_rdata = '0;
    got_err   = 1'b0;
    @(posedge clk);
    #1;
    req   = 1'b1;
    we    = write;
    addr  = a;
    wdata = d;
    be    = b;
    cnt   = 0;
    while (ack !== 1'b1 && cnt < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (ack !== 1'b1) begin
      $display("ERROR: no acknowledge within %0d cycles for address %h", WAIT_LIMIT, a);
      timeouts++;
      ok = 1'b0;
    end else begin
      got_rdata = rdata;
      got_err   = err;
      // Master holds the request past the acknowledge
      hold = $urandom % 4;
      repeat (hold) begin
        @(posedge clk);
        #1;
        check_value("ack_o", 128'(ack), 128'(1'b1));
        check_value("rdata_o", rdata, got_rdata);
      end
      req = 1'b0;
      cnt = 0;
      while (ack !== 1'b0 && cnt < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        cnt++;
      end
      if (ack !== 1'b0) begin
        $display("ERROR: acknowledge stayed high after the request fell, address %h", a);
        timeouts++;
        ok = 1'b0;
      end
    end
    gap = $urandom % 4;
    repeat (gap) @(posedge clk);
  endtask

  task automatic run_test(input logic [1:0] op, input logic [31:0] a, input logic [127:0] d,
                          input logic [15:0] b, input logic [127:0] exp_rdata,
                          input logic exp_err, output logic ok);
    int           xfers_before;
    logic [127:0] got_rdata;
    logic         got_err;
    ok = 1'b1;
    case (op)
      OP_EXIT:   check_value("exit_o", 128'(exit_val), exp_rdata);
      OP_CNT_EN: check_value("hw_cnt_en_o", 128'(cnt_en), exp_rdata);
      OP_READ, OP_WRITE: begin
        xfers_before = apb_xfers;
        do_access(op == OP_WRITE, a, d, b, got_rdata, got_err, ok);
        if (ok) begin
          check_value("rdata_o", got_rdata, exp_rdata);
          check_value("err_o", 128'(got_err), 128'(exp_err));
          if (a[31:12] == 20'hC0000) begin
            check_value("apb transfers", 128'(apb_xfers - xfers_before), 128'(1));
            check_value("uart_psel_o", 128'(apb_setup), 128'(1'b1));
            check_value("uart_paddr_o", 128'(apb_addr), 128'(a));
            check_value("uart_pwrite_o", 128'(apb_write), 128'(op == OP_WRITE));
            if (op == OP_WRITE) begin
              check_value("uart_pwdata_o", 128'(apb_wdata), 128'(pick_lane(d, a)));
            end
          end
        end
      end
    endcase
  endtask

  task automatic report_summary();
    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int          n_tests;
    int          base;
    int unsigned cnt;
    logic        ok;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    be       = '0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    void'($urandom(32'h9a53));
    for (int i = 0; i < MAX_TESTS*FIELDS; i++) begin
      tests[i] = '1;
    end
    $readmemh("dv/soc_tests.txt", tests);
    n_tests = 0;
    while (n_tests < MAX_TESTS && tests[n_tests*FIELDS] <= 128'd3) begin
      n_tests++;
    end
    ok = 1'b1;
    if (n_tests == 0) begin
      $display("ERROR: no tests were read from dv/soc_tests.txt");
      errors++;
      ok = 1'b0;
    end
    cnt = 0;
    while (reset !== 1'b0 && cnt < RESET_LIMIT) begin
      @(posedge clk);
      cnt++;
    end
    if (reset !== 1'b0) begin
      $display("ERROR: reset was never released");
      timeouts++;
      ok = 1'b0;
    end
    for (int t = 0; t < n_tests && ok; t++) begin
      base = t * FIELDS;
      run_test(tests[base][1:0], tests[base+1][31:0], tests[base+2], tests[base+3][15:0],
               tests[base+4], tests[base+5][0], ok);
    end
    report_summary();
  end

endmodule

// File: dv/soc_tests.txt
// op addr wdata be exp_rdata exp_err
// op 0 read, 1 write, 2 check exit_o, 3 check hw_cnt_en_o against exp_rdata
1 80000000 00112233445566778899AABBCCDDEEFF FFFF 00000000000000000000000000000000 0
1 80000010 0123456789ABCDEFFEDCBA9876543210 FFFF 00000000000000000000000000000000 0
1 80000000 FFEEDDCCBBAA99887766554433221100 0F0F 00000000000000000000000000000000 0
0 80000000 00000000000000000000000000000000 0000 00112233BBAA99888899AABB33221100 0
1 80000010 AAAAAAAABBBBBBBBCCCCCCCCDDDDDDDD 8421 00000000000000000000000000000000 0
0 80000010 00000000000000000000000000000000 0000 AA23456789BBCDEFFEDCCC98765432DD 0
1 80000FF0 CAFEF00DDEADBEEF0BADC0DE12345678 FFFF 00000000000000000000000000000000 0
1 80000FF0 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000 00000000000000000000000000000000 0
0 80000FF0 00000000000000000000000000000000 0000 CAFEF00DDEADBEEF0BADC0DE12345678 0
1 D0000000 FFFFFFFFFFFFFFFFFFFFFFFF11223344 FFFF 00000000000000000000000000000000 0
1 D0000004 AAAAAAAAAAAAAAAA55667788AAAAAAAA FFFF 00000000000000000000000000000000 0
1 D0000008 00000000DEADBEEF0000000000000000 0300 00000000000000000000000000000000 0
1 D000000C 87654321000000000000000000000000 F000 00000000000000000000000000000000 0
2 00000000 00000000000000000000000000000000 0000 00000000000000005566778811223344 0
3 00000000 00000000000000000000000000000000 0000 0000000000000000876543210000BEEF 0
0 D0000004 00000000000000000000000000000000 0000 00000000000000005566778800000000 0
0 D0000008 00000000000000000000000000000000 0000 000000000000BEEF0000000000000000 0
0 D000000C 00000000000000000000000000000000 0000 87654321000000000000000000000000 0
0 D0000010 00000000000000000000000000000000 0000 00000000000000000000000080000000 0
1 D0000014 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FFFF 00000000000000000000000000000000 0
0 D0000014 00000000000000000000000000000000 0000 00000000000000000000100000000000 0
2 00000000 00000000000000000000000000000000 0000 00000000000000005566778811223344 0
0 D0000020 00000000000000000000000000000000 0000 00000000000000000000000000000000 0
1 C0000008 00000000123456780000000000000000 FFFF 00000000000000000000000000000000 0
0 C0000104 00000000000000000000000000000000 0000 00000000000000009A5A5B5E00000000 0
0 C000080C 00000000000000000000000000000000 0000 9A5A5256000000000000000000000000 1
1 C0000FF0 000000000000000000000000ABCD0123 FFFF 00000000000000000000000000000000 1
0 00001000 00000000000000000000000000000000 0000 00000000000000000000000000000000 1
1 40000000 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FFFF 00000000000000000000000000000000 1
0 D0001000 00000000000000000000000000000000 0000 00000000000000000000000000000000 1
0 80000010 00000000000000000000000000000000 0000 AA23456789BBCDEFFEDCCC98765432DD 0

// File: list.f
verilog/soc_pkg.sv
verilog/soc_bus_if.sv
verilog/l2_lane_bank.sv
verilog/l2_read_merge.sv
verilog/uart_apb_bridge.sv
verilog/ctrl_registers.sv
verilog/soc_addr_decoder.sv
verilog/soc_top.sv
dv/tb_clock_gen.sv
dv/tb_soc_asserts.sv
dv/tb_soc.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_soc -f list.f -o tb_soc_sim
./obj_dir/tb_soc_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
